/* verilog/cronoPkg.sv */
package cronoPkg;

    // Two BCD digits, tens in the upper nibble
    typedef logic [7:0] bcd_t;

    typedef struct packed {
        bcd_t hours;
        bcd_t minutes;
        bcd_t seconds;
    } timeBcd_t;

    // Raw levels and edge pulses share this layout
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } buttons_t;

    typedef enum logic [1:0] {
        fieldSeconds = 2'd0,
        fieldMinutes = 2'd1,
        fieldHours   = 2'd2,
        fieldRunning = 2'd3 // No field under edit
    } editField_e;

    typedef enum logic [1:0] {
        stateProgramming = 2'd0,
        stateIdle        = 2'd1,
        stateActive      = 2'd2,
        stateRinging     = 2'd3
    } cronoState_e;

    // RTC control register values
    typedef enum logic [7:0] {
        rtcStop  = 8'h00,
        rtcStart = 8'h08
    } rtcCmd_e;

    localparam logic [7:0] CursorSeconds = 8'h41;
    localparam logic [7:0] CursorMinutes = 8'h42;
    localparam logic [7:0] CursorHours   = 8'h43;
    localparam logic [7:0] CursorNone    = 8'h00;

    localparam bcd_t MaxSeconds = 8'h59;
    localparam bcd_t MaxMinutes = 8'h59;
    localparam bcd_t MaxHours   = 8'h23;

    localparam logic [7:0] RtcControlAddress = 8'h00;

endpackage

/* verilog/buttonEdges.sv */
module buttonEdges (
    input  logic              clk,
    input  logic              Reset,
    input  cronoPkg::buttons_t buttons,
    output cronoPkg::buttons_t pulses
);
    import cronoPkg::*;

    buttons_t syncStage1;
    buttons_t syncStage2;
    buttons_t lastLevel; // Previous synchronised level
    buttons_t rising;

    // Two-flop synchroniser plus history for the edge compare
    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            syncStage1 <= '0;
            syncStage2 <= '0;
            lastLevel  <= '0;
        end else begin
            syncStage1 <= buttons;
            syncStage2 <= syncStage1;
            lastLevel  <= syncStage2;
        end
    end

    assign rising = syncStage2 & ~lastLevel;

    // One-hot pulse, up wins over down over left over right
    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            pulses <= '0;
        end else begin
            pulses <= '0;
            if (rising.up) begin
                pulses.up <= 1'b1;
            end else if (rising.down) begin
                pulses.down <= 1'b1;
            end else if (rising.left) begin
                pulses.left <= 1'b1;
            end else if (rising.right) begin
                pulses.right <= 1'b1;
            end
        end
    end

endmodule

/* verilog/targetEditor.sv */
module targetEditor (
    input  logic               clk,
    input  logic               Reset,
    input  cronoPkg::buttons_t pulses,
    input  logic               programMode,
    input  logic               start,
    input  logic               finished,
    output cronoPkg::timeBcd_t targetTime,
    output logic [7:0]         cursor
);
    import cronoPkg::*;

    editField_e fieldState;
    logic       editEnable;
    bcd_t       fieldValue;
    bcd_t       fieldLimit;
    bcd_t       steppedValue;
    logic [7:0] fieldCode;

    // BCD increment, held at the field limit
    function automatic bcd_t stepUp(input bcd_t value, input bcd_t limit);
        bcd_t result;
        if (value >= limit) begin
            result = limit;
        end else if (value[3:0] == 4'h9) begin
            result = {value[7:4] + 4'h1, 4'h0}; // Carry into tens
        end else begin
            result = value + 8'h01;
        end
        return result;
    endfunction

    // BCD decrement, held at 00
    function automatic bcd_t stepDown(input bcd_t value);
        bcd_t result;
        if (value == 8'h00) begin
            result = 8'h00;
        end else if (value[3:0] == 4'h0) begin
            result = {value[7:4] - 4'h1, 4'h9}; // Borrow from tens
        end else begin
            result = value - 8'h01;
        end
        return result;
    endfunction

    assign editEnable = programMode && !start && !finished;

    // Value and limit of the field under the cursor
    always_comb begin
        fieldValue = targetTime.seconds;
        fieldLimit = MaxSeconds;
        case (fieldState)
            fieldMinutes: begin
                fieldValue = targetTime.minutes;
                fieldLimit = MaxMinutes;
            end
            fieldHours: begin
                fieldValue = targetTime.hours;
                fieldLimit = MaxHours;
            end
            default: ;
        endcase
        steppedValue = pulses.up ? stepUp(fieldValue, fieldLimit) : stepDown(fieldValue);
    end

    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            fieldState <= fieldRunning;
            targetTime <= '0;
        end else begin
            if (!programMode || start) begin
                fieldState <= fieldRunning; // Left edit mode
            end else if (fieldState == fieldRunning) begin
                fieldState <= fieldSeconds; // Edit always starts on seconds
            end else if (editEnable) begin
                if (pulses.left) begin
                    // Cursor moves toward hours
                    case (fieldState)
                        fieldSeconds: fieldState <= fieldMinutes;
                        fieldMinutes: fieldState <= fieldHours;
                        default:      fieldState <= fieldHours;
                    endcase
                end else if (pulses.right) begin
                    case (fieldState)
                        fieldHours:   fieldState <= fieldMinutes;
                        fieldMinutes: fieldState <= fieldSeconds;
                        default:      fieldState <= fieldSeconds;
                    endcase
                end else if (pulses.up || pulses.down) begin
                    case (fieldState)
                        fieldSeconds: targetTime.seconds <= steppedValue;
                        fieldMinutes: targetTime.minutes <= steppedValue;
                        fieldHours:   targetTime.hours   <= steppedValue;
                        default: ;
                    endcase
                end
            end
        end
    end

    always_comb begin
        case (fieldState)
            fieldSeconds: fieldCode = CursorSeconds;
            fieldMinutes: fieldCode = CursorMinutes;
            fieldHours:   fieldCode = CursorHours;
            default:      fieldCode = CursorNone;
        endcase
    end

    // Blank the cursor as soon as edit mode drops
    assign cursor = (programMode && !start) ? fieldCode : CursorNone;

endmodule

/* verilog/runControl.sv */
module runControl (
    input  logic               clk,
    input  logic               Reset,
    input  logic               start,
    input  cronoPkg::timeBcd_t rtcTime,
    input  cronoPkg::timeBcd_t targetTime,
    output logic               finished,
    output logic               cronoActive,
    output logic               ring
);
    import cronoPkg::*;

    cronoState_e state;
    cronoState_e nextState;
    logic        timeMatch;

    // A zero target never counts as reached
    assign timeMatch = (rtcTime == targetTime) && (targetTime != '0);

    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            finished <= 1'b0;
        end else begin
            finished <= timeMatch;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            stateProgramming: begin
                if (finished) begin
                    nextState = stateRinging;
                end else if (start) begin
                    nextState = stateActive;
                end else begin
                    nextState = stateIdle;
                end
            end
            stateIdle: begin
                if (finished) begin
                    nextState = stateRinging;
                end else if (start) begin
                    nextState = stateActive;
                end
            end
            stateActive: begin
                if (finished) begin
                    nextState = stateRinging;
                end else if (!start) begin
                    nextState = stateIdle;
                end
            end
            stateRinging: begin
                // Hold the alarm until the match and the run request are gone
                if (!finished && !start) begin
                    nextState = stateProgramming;
                end
            end
            default: nextState = stateProgramming;
        endcase
    end

    // Outputs registered alongside the state
    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            state       <= stateProgramming;
            cronoActive <= 1'b0;
            ring        <= 1'b0;
        end else begin
            state       <= nextState;
            cronoActive <= (nextState == stateActive);
            ring        <= (nextState == stateRinging);
        end
    end

endmodule

/* verilog/rtcCommand.sv */
module rtcCommand #(
    parameter int HoldCycles = 338
) (
    input  logic              clk,
    input  logic              Reset,
    input  logic              cronoActive,
    output logic [7:0]        rtcAddress,
    output cronoPkg::rtcCmd_e rtcData,
    output logic              rtcWrite
);
    import cronoPkg::*;

    localparam int CountWidth = $clog2(HoldCycles + 1);

    logic                  lastActive;
    logic                  activeChange;
    logic [CountWidth-1:0] holdCount;

    assign activeChange = (cronoActive != lastActive);

    // A new change reloads the counter, even mid-hold
    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            lastActive <= 1'b0;
            holdCount  <= '0;
        end else begin
            lastActive <= cronoActive;
            if (activeChange) begin
                holdCount <= CountWidth'(HoldCycles);
            end else if (holdCount != '0) begin
                holdCount <= holdCount - 1'b1;
            end
        end
    end

    assign rtcWrite = (holdCount != '0);

    assign rtcAddress = RtcControlAddress; // Only the control register is written

    // lastActive already holds the level that triggered the hold
    always_comb begin
        if (rtcWrite) begin
            rtcData = lastActive ? rtcStart : rtcStop;
        end else begin
            rtcData = rtcStop; // Bus idles at zero
        end
    end

endmodule

/* verilog/cronoTop.sv */
module cronoTop #(
    parameter int HoldCycles = 338
) (
    input  logic               clk,
    input  logic               Reset,
    input  logic               programMode,
    input  logic               start,
    input  cronoPkg::timeBcd_t rtcTime,
    input  cronoPkg::buttons_t buttons,
    output logic               cronoActive,
    output logic               ring,
    output logic [7:0]         cursor,
    output cronoPkg::timeBcd_t targetTime,
    output logic [7:0]         rtcAddress,
    output cronoPkg::rtcCmd_e  rtcData,
    output logic               rtcWrite
);
    import cronoPkg::*;

    buttons_t pulses;   // One-hot button strobes
    logic     finished; // Registered time match

    buttonEdges buttonEdgesInst (
        .clk     (clk),
        .Reset   (Reset),
        .buttons (buttons),
        .pulses  (pulses)
    );

    targetEditor targetEditorInst (
        .clk         (clk),
        .Reset       (Reset),
        .pulses      (pulses),
        .programMode (programMode),
        .start       (start),
        .finished    (finished),
        .targetTime  (targetTime),
        .cursor      (cursor)
    );

    runControl runControlInst (
        .clk         (clk),
        .Reset       (Reset),
        .start       (start),
        .rtcTime     (rtcTime),
        .targetTime  (targetTime),
        .finished    (finished),
        .cronoActive (cronoActive),
        .ring        (ring)
    );

    rtcCommand #(
        .HoldCycles (HoldCycles)
    ) rtcCommandInst (
        .clk         (clk),
        .Reset       (Reset),
        .cronoActive (cronoActive),
        .rtcAddress  (rtcAddress),
        .rtcData     (rtcData),
        .rtcWrite    (rtcWrite)
    );

endmodule

/* test/cronoTop_checker.sv */
module cronoTop_checker (
    input logic       clk,
    input logic       Reset,
    input logic       programMode,
    input logic       cronoActive,
    input logic       ring,
    input logic [7:0] cursor,
    input logic       rtcWrite
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0; // Failed assertions so far

    // Every run-state change must show up on the RTC bus next cycle
    activeChangeWrite: assert property (@(posedge clk) disable iff (Reset)
        (cronoActive != $past(cronoActive)) |=> rtcWrite)
        else begin
            failCount++;
            $error("rtcWrite did not rise after a change of cronoActive");
        end

    activeRingExclusive: assert property (@(posedge clk) disable iff (Reset)
        !(cronoActive && ring))
        else begin
            failCount++;
            $error("cronoActive and ring are high together");
        end

    // No field may be shown outside programming mode
    cursorBlank: assert property (@(posedge clk) disable iff (Reset)
        !programMode |-> (cursor == 8'h00))
        else begin
            failCount++;
            $error("cursor is not blank while programMode is low");
        end

endmodule

bind cronoTop cronoTop_checker outputChecks (
    .clk         (clk),
    .Reset       (Reset),
    .programMode (programMode),
    .cronoActive (cronoActive),
    .ring        (ring),
    .cursor      (cursor),
    .rtcWrite    (rtcWrite)
);

/* test/cronoTb.sv */
module cronoTb;
    timeunit 1ns;
    timeprecision 1ps;

    import cronoPkg::*;

    localparam int HoldCycles    = 6;
    localparam int TimeoutCycles = 3000; // Edit presses dominate, about 1300 cycles
    localparam int SecondsLimit  = 59;
    localparam int MinutesLimit  = 59;
    localparam int HoursLimit    = 23;

    localparam buttons_t PressUp    = '{up: 1'b1, down: 1'b0, left: 1'b0, right: 1'b0};
    localparam buttons_t PressDown  = '{up: 1'b0, down: 1'b1, left: 1'b0, right: 1'b0};
    localparam buttons_t PressLeft  = '{up: 1'b0, down: 1'b0, left: 1'b1, right: 1'b0};
    localparam buttons_t PressRight = '{up: 1'b0, down: 1'b0, left: 1'b0, right: 1'b1};

    logic       clk;
    logic       Reset;
    logic       programMode;
    logic       start;
    timeBcd_t   rtcTime;
    buttons_t   buttons;
    logic       cronoActive;
    logic       ring;
    logic [7:0] cursor;
    timeBcd_t   targetTime;
    logic [7:0] rtcAddress;
    rtcCmd_e    rtcData;
    logic       rtcWrite;

    integer seed;
    int     cycleCount = 0;
    int     secondsCount; // Target model as plain integers
    int     minutesCount;
    int     hoursCount;

    cronoTop #(
        .HoldCycles (HoldCycles)
    ) uut (
        .clk         (clk),
        .Reset       (Reset),
        .programMode (programMode),
        .start       (start),
        .rtcTime     (rtcTime),
        .buttons     (buttons),
        .cronoActive (cronoActive),
        .ring        (ring),
        .cursor      (cursor),
        .targetTime  (targetTime),
        .rtcAddress  (rtcAddress),
        .rtcData     (rtcData),
        .rtcWrite    (rtcWrite)
    );

    always #4 clk = ~clk;

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            stopWithFailure($sformatf("Timeout: tests still running after %0d cycles", cycleCount));
        end
    end

    task automatic checkHex(input string name, input logic [23:0] expected,
                            input logic [23:0] actual);
        assert (actual === expected) else
            stopWithFailure($sformatf("FAIL %s expected %h got %h", name, expected, actual));
    endtask

    function automatic int saturate(input int value, input int limit);
        int result;
        result = value;
        if (result > limit) result = limit;
        if (result < 0) result = 0;
        return result;
    endfunction

    // Decimal count to two BCD digits
    function automatic logic [7:0] toBcd(input int value);
        logic [7:0] result;
        result[7:4] = 4'(value / 10);
        result[3:0] = 4'(value % 10);
        return result;
    endfunction

    function automatic timeBcd_t expectedTarget();
        timeBcd_t result;
        result.hours   = toBcd(hoursCount);
        result.minutes = toBcd(minutesCount);
        result.seconds = toBcd(secondsCount);
        return result;
    endfunction

    task automatic waitCycles(input int count);
        repeat (count) @(posedge clk);
    endtask

    task automatic applyReset();
        Reset <= 1'b1;
        waitCycles(4);
        Reset <= 1'b0;
    endtask

    // Hold long enough for the synchroniser, then release for the next edge
    task automatic pressButton(input buttons_t press, input int count);
        repeat (count) begin
            @(posedge clk);
            buttons <= press;
            waitCycles(4);
            buttons <= '0;
            waitCycles(3);
        end
        @(negedge clk);
    endtask

    // Polls ring or cronoActive at falling edges
    task automatic waitForOutput(input bit watchRing, input logic expected, input int limit);
        int   waited;
        logic observed;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            observed = watchRing ? ring : cronoActive;
        end while (observed !== expected && waited < limit);
        assert (observed === expected) else
            stopWithFailure($sformatf("%s did not reach %0b within %0d cycles",
                                      watchRing ? "ring" : "cronoActive", expected, limit));
    endtask

    task automatic testResetValues();
        @(negedge clk);
        checkHex("cronoActive", 1'b0, cronoActive);
        checkHex("ring", 1'b0, ring);
        checkHex("rtcWrite", 1'b0, rtcWrite);
        checkHex("cursor", 8'h00, cursor);
        checkHex("targetTime", 24'h000000, targetTime);
    endtask

    task automatic testFieldEditing();
        int presses;
        @(posedge clk);
        programMode <= 1'b1;
        waitCycles(3);
        @(negedge clk);
        checkHex("cursor", 8'h41, cursor);
        presses = ($unsigned($random(seed)) % 70) + 1;
        pressButton(PressUp, presses);
        secondsCount = saturate(secondsCount + presses, SecondsLimit);
        checkHex("targetTime", expectedTarget(), targetTime);
        pressButton(PressLeft, 1);
        checkHex("cursor", 8'h42, cursor);
        pressButton(PressLeft, 2); // Second one hits the hours end stop
        checkHex("cursor", 8'h43, cursor);
        presses = 24 + ($unsigned($random(seed)) % 8);
        pressButton(PressUp, presses);
        hoursCount = saturate(hoursCount + presses, HoursLimit);
        checkHex("targetTime.hours", 8'h23, targetTime.hours);
        presses = 24 + ($unsigned($random(seed)) % 4);
        pressButton(PressDown, presses);
        hoursCount = saturate(hoursCount - presses, HoursLimit);
        checkHex("targetTime.hours", 8'h00, targetTime.hours);
        pressButton(PressRight, 1);
        checkHex("cursor", 8'h42, cursor);
        pressButton(PressUp, 12); // Carry from 09 to 10
        minutesCount = saturate(minutesCount + 12, MinutesLimit);
        pressButton(PressDown, 3); // Borrow from 10 back to 09
        minutesCount = saturate(minutesCount - 3, MinutesLimit);
        checkHex("targetTime", expectedTarget(), targetTime);
    endtask

    task automatic testStartStop();
        @(posedge clk);
        programMode <= 1'b0;
        waitCycles(3);
        @(negedge clk);
        checkHex("cursor", 8'h00, cursor);
        @(posedge clk);
        start <= 1'b1;
        waitForOutput(0, 1'b1, 6);
        checkHex("ring", 1'b0, ring);
        waitCycles(12);
        start <= 1'b0;
        waitForOutput(0, 1'b0, 6);
        checkHex("ring", 1'b0, ring);
        waitCycles(12);
    endtask

    task automatic measureCommand(input logic startLevel, input logic [7:0] expectedData);
        int highCycles;
        @(posedge clk);
        start <= startLevel;
        waitForOutput(0, startLevel, 6);
        checkHex("rtcWrite", 1'b0, rtcWrite); // Rises on the following cycle
        @(negedge clk);
        highCycles = 0;
        while (rtcWrite === 1'b1 && highCycles <= HoldCycles + 2) begin
            checkHex("rtcAddress", 8'h00, rtcAddress);
            checkHex("rtcData", expectedData, rtcData);
            highCycles++;
            @(negedge clk);
        end
        checkHex("write length", HoldCycles, highCycles);
        repeat (4) begin
            checkHex("rtcWrite", 1'b0, rtcWrite);
            checkHex("rtcData", 8'h00, rtcData);
            @(negedge clk);
        end
    endtask

    task automatic testRtcCommands();
        measureCommand(1'b1, 8'h08);
        measureCommand(1'b0, 8'h00);
    endtask

    task automatic testRingOnMatch();
        @(posedge clk);
        start <= 1'b1;
        waitForOutput(0, 1'b1, 6);
        @(posedge clk);
        rtcTime <= expectedTarget();
        waitForOutput(1, 1'b1, 6);
        checkHex("cronoActive", 1'b0, cronoActive);
        @(posedge clk);
        rtcTime <= '0; // Match gone but start still high
        waitCycles(6);
        @(negedge clk);
        checkHex("ring", 1'b1, ring);
        @(posedge clk);
        start <= 1'b0;
        waitForOutput(1, 1'b0, 6);
        checkHex("cronoActive", 1'b0, cronoActive);
        // Cleared target against a zero RTC time
        @(posedge clk);
        applyReset();
        secondsCount = 0;
        minutesCount = 0;
        hoursCount   = 0;
        start <= 1'b1;
        waitForOutput(0, 1'b1, 6);
        repeat (10) begin
            checkHex("ring", 1'b0, ring);
            @(negedge clk);
        end
        checkHex("targetTime", 24'h000000, targetTime);
        @(posedge clk);
        start <= 1'b0;
        waitForOutput(0, 1'b0, 6);
    endtask

    initial begin
        seed         = 32'h67ec;
        clk          = 1'b0;
        Reset        = 1'b1;
        programMode  = 1'b0;
        start        = 1'b0;
        rtcTime      = '0;
        buttons      = '0;
        secondsCount = 0;
        minutesCount = 0;
        hoursCount   = 0;
        applyReset();
        testResetValues();
        testFieldEditing();
        testStartStop();
        testRtcCommands();
        testRingOnMatch();
        if (uut.outputChecks.failCount != 0) begin
            stopWithFailure($sformatf("%0d bound assertions failed",
                                      uut.outputChecks.failCount));
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

/* files.f */
verilog/cronoPkg.sv
verilog/buttonEdges.sv
verilog/targetEditor.sv
verilog/runControl.sv
verilog/rtcCommand.sv
verilog/cronoTop.sv
test/cronoTop_checker.sv
test/cronoTb.sv

/* Makefile */
# Verilator simulation of the countdown timer testbench

VERILATOR ?= verilator
TOP       ?= cronoTb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale $(TIMESCALE)

.PHONY: sim clean

# A failing run exits nonzero through $$fatal, so make fails too
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
